//--- include/i2c_defines.svh
// i2c master constants

`ifndef I2C_DEFINES_SVH
`define I2C_DEFINES_SVH

// ----------------------------------------------------------------------
// device and word widths
// ----------------------------------------------------------------------
`define I2C_SLAVE_ADDR      7'h50   // default 7-bit device address
`define I2C_ADDR_W          16      // word address, 16 or 8 bits used
`define I2C_DATA_W          8
`define I2C_CNT_W           7       // phase cycle counter

// ----------------------------------------------------------------------
// phase lengths, in dri_clk cycles
// ----------------------------------------------------------------------
`define I2C_LEN_START_BYTE  40      // start or restart, byte, ack
`define I2C_LEN_BYTE        36      // byte plus ack slot
`define I2C_LEN_STOP        17
`define I2C_PRE_START       4       // preamble ahead of the first bit slot

// ----------------------------------------------------------------------
// cycle positions inside one 4-cycle bit slot
// ----------------------------------------------------------------------
`define I2C_POS_SDA         0       // sda changes, scl low
`define I2C_POS_SCL_RISE    1       // read bits sampled here
`define I2C_POS_SCL_FALL    3
`define I2C_ACK_SLOT        8       // ninth slot holds ack or nack

`endif

//--- src/i2c_pkg.sv
// i2c master types

`default_nettype none

`include "i2c_defines.svh"

package i2c_pkg;

    // bus phase currently shaped by the phase generator
    typedef enum logic [2:0] {
        ph_idle         = 3'd0,
        ph_start_byte   = 3'd1,     // start, slave address, ack
        ph_restart_byte = 3'd2,     // repeated start, slave address, ack
        ph_tx_byte      = 3'd3,
        ph_rx_byte      = 3'd4,     // byte in, master nack
        ph_stop         = 3'd5
    } phase_e;

    // transaction controller states
    typedef enum logic [2:0] {
        idle    = 3'd0,
        sladdr  = 3'd1,
        addr_hi = 3'd2,
        addr_lo = 3'd3,
        data_wr = 3'd4,
        addr_rd = 3'd5,
        data_rd = 3'd6,
        stop    = 3'd7
    } txn_state_e;

    // word address, whole or split into the two bytes sent on the bus
    typedef union packed {
        logic [`I2C_ADDR_W-1:0] word;
        struct packed {
            logic [`I2C_DATA_W-1:0] hi;
            logic [`I2C_DATA_W-1:0] lo;
        } bytes;
    } word_addr_u;

endpackage

`default_nettype wire

//--- src/i2c_txn_ctrl.sv
// i2c transaction controller

`timescale 1ns/1ps
`default_nettype none

`include "i2c_defines.svh"

module i2c_txn_ctrl #(
    parameter logic [6:0] slave_addr = `I2C_SLAVE_ADDR
) (
    input  wire                     dri_clk,
    input  wire                     rst_n,
    input  wire                     i2c_exec,
    input  wire                     bit_ctrl,
    input  wire                     i2c_rh_wl,
    input  wire [`I2C_ADDR_W-1:0]   i2c_addr,
    input  wire [`I2C_DATA_W-1:0]   i2c_data_w,
    input  wire                     phase_end,
    output i2c_pkg::phase_e         phase_kind,
    output logic [`I2C_DATA_W-1:0]  tx_byte,
    output logic                    i2c_done
);
    import i2c_pkg::*;

    txn_state_e             state;
    txn_state_e             state_nxt;
    logic                   rd_q;       // 1 = read transaction
    logic                   wide_q;     // 1 = 16-bit word address
    word_addr_u             addr_q;
    logic [`I2C_DATA_W-1:0] data_q;

    // ----------------------------------------------------------------------
    // state register and next state
    // ----------------------------------------------------------------------
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            idle: begin
                if (i2c_exec) begin
                    state_nxt = sladdr;
                end
            end
            sladdr: begin
                if (phase_end) begin
                    state_nxt = wide_q ? addr_hi : addr_lo;
                end
            end
            addr_hi: if (phase_end) state_nxt = addr_lo;
            addr_lo: begin
                if (phase_end) begin
                    state_nxt = rd_q ? addr_rd : data_wr;
                end
            end
            data_wr: if (phase_end) state_nxt = stop;
            addr_rd: if (phase_end) state_nxt = data_rd;
            data_rd: if (phase_end) state_nxt = stop;
            stop:    if (phase_end) state_nxt = idle;
            default: state_nxt = idle;
        endcase
    end

    // request taken only from idle, later pulses are dropped
    always_ff @(posedge dri_clk) begin
        if (state == idle && i2c_exec) begin
            rd_q        <= i2c_rh_wl;
            wide_q      <= bit_ctrl;
            addr_q.word <= i2c_addr;
            data_q      <= i2c_data_w;
        end
    end

    // ----------------------------------------------------------------------
    // phase kind and byte per state
    // ----------------------------------------------------------------------
    always_comb begin
        case (state)
            sladdr:                    phase_kind = ph_start_byte;
            addr_hi, addr_lo, data_wr: phase_kind = ph_tx_byte;
            addr_rd:                   phase_kind = ph_restart_byte;
            data_rd:                   phase_kind = ph_rx_byte;
            stop:                      phase_kind = ph_stop;
            default:                   phase_kind = ph_idle;
        endcase
    end

    always_comb begin
        case (state)
            sladdr:  tx_byte = {slave_addr, 1'b0};  // write
            addr_hi: tx_byte = addr_q.bytes.hi;
            addr_lo: tx_byte = addr_q.bytes.lo;
            data_wr: tx_byte = data_q;
            addr_rd: tx_byte = {slave_addr, 1'b1};  // read
            default: tx_byte = '0;
        endcase
    end

    // done on the edge that leaves stop
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            i2c_done <= 1'b0;
        end else begin
            i2c_done <= (state == stop) && phase_end;
        end
    end

    // ----------------------------------------------------------------------
    // checks against the phase generator
    // ----------------------------------------------------------------------
    a_done_pulse: assert property (@(posedge dri_clk) disable iff (!rst_n)
        i2c_done |=> !i2c_done)
        else $error("i2c_done held for more than one cycle");

    a_phase_hold: assert property (@(posedge dri_clk) disable iff (!rst_n)
        (phase_kind != $past(phase_kind)) && ($past(phase_kind) != ph_idle)
        |-> $past(phase_end))
        else $error("phase_kind changed without phase_end");

endmodule

`default_nettype wire

//--- src/i2c_phase_gen.sv
// i2c bus phase generator

`timescale 1ns/1ps
`default_nettype none

`include "i2c_defines.svh"

module i2c_phase_gen (
    input  wire                     dri_clk,
    input  wire                     rst_n,
    input  wire i2c_pkg::phase_e    phase_kind,
    input  wire [`I2C_DATA_W-1:0]   tx_byte,
    input  wire                     sda_in,
    output logic                    scl,
    output logic                    sda_out,
    output logic                    sda_oe,
    output logic                    phase_end,
    output logic [`I2C_DATA_W-1:0]  rx_byte
);
    import i2c_pkg::*;

    typedef logic [`I2C_CNT_W-1:0] cnt_t;

    localparam cnt_t       len_start_byte = cnt_t'(`I2C_LEN_START_BYTE);
    localparam cnt_t       len_byte       = cnt_t'(`I2C_LEN_BYTE);
    localparam cnt_t       len_stop       = cnt_t'(`I2C_LEN_STOP);
    localparam cnt_t       pre_start      = cnt_t'(`I2C_PRE_START);
    localparam logic [1:0] pos_sda        = 2'(`I2C_POS_SDA);
    localparam logic [1:0] pos_scl_rise   = 2'(`I2C_POS_SCL_RISE);
    localparam logic [1:0] pos_scl_fall   = 2'(`I2C_POS_SCL_FALL);
    localparam logic [3:0] ack_slot       = 4'(`I2C_ACK_SLOT);

    cnt_t                   cnt;        // cycle within the phase
    cnt_t                   phase_len;
    cnt_t                   pre_len;
    cnt_t                   rel;        // cycle counted from the first bit slot
    logic [3:0]             slot;       // 0..7 data bits, 8 ack
    logic [1:0]             pos;
    logic                   in_pre;
    logic                   is_restart;
    logic                   is_rx;
    logic [`I2C_DATA_W-1:0] shift_q;

    // ----------------------------------------------------------------------
    // phase decode
    // ----------------------------------------------------------------------
    always_comb begin
        case (phase_kind)
            ph_start_byte, ph_restart_byte: phase_len = len_start_byte;
            ph_tx_byte, ph_rx_byte:         phase_len = len_byte;
            ph_stop:                        phase_len = len_stop;
            default:                        phase_len = '0;
        endcase
    end

    assign is_restart = (phase_kind == ph_restart_byte);
    assign is_rx      = (phase_kind == ph_rx_byte);
    assign pre_len    = (phase_kind == ph_start_byte || is_restart) ? pre_start : '0;
    assign in_pre     = (cnt < pre_len);
    assign rel        = cnt - pre_len;
    assign slot       = rel[5:2];
    assign pos        = rel[1:0];

    // ----------------------------------------------------------------------
    // cycle counter, phase_end one cycle ahead of the wrap
    // ----------------------------------------------------------------------
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt       <= '0;
            phase_end <= 1'b0;
        end else if (phase_kind == ph_idle) begin
            cnt       <= '0;
            phase_end <= 1'b0;
        end else begin
            phase_end <= (cnt == phase_len - cnt_t'(2));
            cnt       <= phase_end ? '0 : cnt + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // scl and sda shaping
    // ----------------------------------------------------------------------
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            scl     <= 1'b1;
            sda_out <= 1'b1;
            sda_oe  <= 1'b1;
        end else begin
            case (phase_kind)
                ph_idle: begin
                    scl     <= 1'b1;
                    sda_out <= 1'b1;
                    sda_oe  <= 1'b1;
                end
                ph_stop: begin
                    case (cnt)
                        cnt_t'(0): begin
                            sda_oe  <= 1'b1;
                            sda_out <= 1'b0;        // low while scl low
                        end
                        cnt_t'(1): scl     <= 1'b1;
                        cnt_t'(3): sda_out <= 1'b1; // stop condition
                        default: ;
                    endcase
                end
                default: begin
                    if (in_pre) begin
                        // start drops sda at 1, restart raises scl first
                        case (cnt[1:0])
                            2'd0: begin
                                sda_oe  <= 1'b1;
                                sda_out <= 1'b1;
                            end
                            2'd1: begin
                                if (is_restart) begin
                                    scl <= 1'b1;
                                end else begin
                                    sda_out <= 1'b0;
                                end
                            end
                            2'd2: if (is_restart) sda_out <= 1'b0;
                            default: scl <= 1'b0;
                        endcase
                    end else begin
                        case (pos)
                            pos_sda: begin
                                if (slot == ack_slot) begin
                                    sda_oe  <= is_rx;   // release for ack, nack after read
                                    sda_out <= 1'b1;
                                end else begin
                                    sda_oe  <= !is_rx;
                                    sda_out <= is_rx ? 1'b1 : tx_byte[3'd7 - slot[2:0]];
                                end
                            end
                            pos_scl_rise: scl <= 1'b1;
                            pos_scl_fall: scl <= 1'b0;
                            default: ;
                        endcase
                    end
                end
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // read data, msb first
    // ----------------------------------------------------------------------
    always_ff @(posedge dri_clk) begin
        if (is_rx && pos == pos_scl_rise && slot != ack_slot) begin
            shift_q <= {shift_q[`I2C_DATA_W-2:0], sda_in};
        end
        if (is_rx && phase_end) begin
            rx_byte <= shift_q;             // held until next read
        end
    end

    a_end_pulse: assert property (@(posedge dri_clk) disable iff (!rst_n)
        phase_end |=> !phase_end)
        else $error("phase_end longer than one cycle");

    a_idle_scl: assert property (@(posedge dri_clk) disable iff (!rst_n)
        (phase_kind == ph_idle) |-> scl)
        else $error("scl low while idle");

endmodule

`default_nettype wire

//--- src/i2c_master.sv
// i2c register access master

`timescale 1ns/1ps
`default_nettype none

`include "i2c_defines.svh"

module i2c_master #(
    parameter logic [6:0] slave_addr = `I2C_SLAVE_ADDR
) (
    input  wire                     dri_clk,    // four times scl rate
    input  wire                     rst_n,
    input  wire                     i2c_exec,
    input  wire                     bit_ctrl,   // 1 = 16-bit word address
    input  wire                     i2c_rh_wl,  // 1 = read
    input  wire [`I2C_ADDR_W-1:0]   i2c_addr,
    input  wire [`I2C_DATA_W-1:0]   i2c_data_w,
    input  wire                     sda_in,     // wired line level
    output wire [`I2C_DATA_W-1:0]   i2c_data_r,
    output wire                     i2c_done,
    output wire                     scl,
    output wire                     sda_out,
    output wire                     sda_oe
);
    import i2c_pkg::*;

    phase_e                 phase_kind;
    logic [`I2C_DATA_W-1:0] tx_byte;
    logic                   phase_end;

    i2c_txn_ctrl #(
        .slave_addr (slave_addr)
    ) i_txn_ctrl (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .i2c_exec   (i2c_exec),
        .bit_ctrl   (bit_ctrl),
        .i2c_rh_wl  (i2c_rh_wl),
        .i2c_addr   (i2c_addr),
        .i2c_data_w (i2c_data_w),
        .phase_end  (phase_end),
        .phase_kind (phase_kind),
        .tx_byte    (tx_byte),
        .i2c_done   (i2c_done)
    );

    i2c_phase_gen i_phase_gen (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .phase_kind (phase_kind),
        .tx_byte    (tx_byte),
        .sda_in     (sda_in),
        .scl        (scl),
        .sda_out    (sda_out),
        .sda_oe     (sda_oe),
        .phase_end  (phase_end),
        .rx_byte    (i2c_data_r)
    );

endmodule

`default_nettype wire

//--- tb/tb_clk_gen.sv
// testbench clock and reset

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 16
) (
    output logic dri_clk,
    output logic rst_n
);

    initial begin
        dri_clk = 1'b0;
        forever #(period_ns / 2) dri_clk = ~dri_clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge dri_clk);
        @(negedge dri_clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- tb/i2c_slave_model.sv
// behavioral i2c slave

`timescale 1ns/1ps
`default_nettype none

`include "i2c_defines.svh"

module i2c_slave_model #(
    parameter logic [6:0] dev_addr = `I2C_SLAVE_ADDR
) (
    input  wire  dri_clk,
    input  wire  rst_n,
    input  wire  scl,
    input  wire  sda_out,
    input  wire  sda_oe,
    input  wire  wide,              // 1 = 16-bit word address
    output wire  sda_line,
    output logic bus_err
);

    logic [7:0]  mem [0:65535];
    logic [7:0]  rx_log [0:255];    // every byte the master wrote
    logic [7:0]  rx_cnt;
    int          n_start;
    int          n_restart;
    int          n_stop;
    int          n_nack;
    logic        pull;              // slave pull-down
    logic        busy;
    logic        scl_q;
    logic        sda_q;
    logic        line;
    logic        rd_mode;
    logic        tx_active;
    logic [3:0]  idx;               // scl rises seen in this byte
    int          byte_idx;
    logic [7:0]  shreg;
    logic [7:0]  tx_q;
    logic [15:0] ptr;

    assign sda_line = (sda_oe ? sda_out : 1'b1) & !pull;   // wired and

    initial begin
        for (int a = 0; a < 65536; a++) begin
            mem[a] = 8'(a >> 8) ^ 8'(a) ^ 8'h5a;
        end
    end

    task automatic flag(input string what);
        $display("slave model: %s", what);
        bus_err = 1'b1;
    endtask

    // write bytes after the device address
    task automatic take_byte(input logic [7:0] b);
        rx_log[rx_cnt] = b;
        rx_cnt = rx_cnt + 8'd1;
        if (byte_idx == 0) begin
            if (b[7:1] != dev_addr) flag("device address does not match");
            rd_mode = b[0];
        end else if (wide && byte_idx == 1) begin
            ptr[15:8] = b;
        end else if ((wide && byte_idx == 2) || (!wide && byte_idx == 1)) begin
            ptr = wide ? {ptr[15:8], b} : {8'h00, b};
        end else begin
            mem[ptr] = b;
            ptr = ptr + 16'd1;
        end
    endtask

    // ----------------------------------------------------------------------
    // bus watcher, sampled mid-cycle where everything is stable
    // ----------------------------------------------------------------------
    always @(negedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            {pull, busy, rd_mode, tx_active, bus_err} = '0;
            n_start   = 0;
            n_restart = 0;
            n_stop    = 0;
            n_nack    = 0;
            {scl_q, sda_q} = 2'b11;
            idx = '0;
            rx_cnt = '0;
            ptr = '0;
        end else begin
            line = sda_line;
            if (pull && sda_oe) flag("master drives sda while the slave pulls it low");
            if (scl && scl_q && line != sda_q) begin
                if (!line) begin                            // start or restart
                    if (busy) n_restart++;
                    else n_start++;
                    busy = 1'b1;
                    idx = '0;
                    byte_idx = 0;
                    {rd_mode, tx_active, pull} = 3'b000;
                end else begin
                    if (!busy) flag("stop outside a transaction");
                    n_stop++;
                    busy = 1'b0;
                    pull = 1'b0;
                end
            end else if (busy && scl && !scl_q) begin       // scl rise
                if (idx < 4'd8) begin
                    if (!tx_active) shreg = {shreg[6:0], line};
                end else if (idx == 4'd8 && tx_active) begin
                    if (!line) flag("read byte acknowledged, nack expected");
                    n_nack++;
                    {tx_active, rd_mode} = 2'b00;
                end
                idx = idx + 4'd1;
            end else if (busy && !scl && scl_q) begin       // scl fall
                if (idx == 4'd8) begin
                    if (tx_active) begin
                        pull = 1'b0;                        // master answers
                    end else begin
                        take_byte(shreg);
                        pull = 1'b1;                        // ack
                    end
                end else if (idx == 4'd9) begin
                    idx = '0;
                    pull = 1'b0;
                    byte_idx++;
                    if (rd_mode) begin
                        tx_q = mem[ptr];
                        tx_active = 1'b1;
                        pull = !tx_q[7];
                    end
                end else if (tx_active && idx != 4'd0) begin
                    pull = !tx_q[3'(4'd7 - idx)];
                end
            end
            scl_q = scl;
            sda_q = line;
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_i2c_master.sv
// i2c master testbench

`timescale 1ns/1ps
`default_nettype none

`include "i2c_defines.svh"

module tb_i2c_master;
    import i2c_pkg::*;

    localparam int num_txn        = 40;
    localparam int timeout_cycles = 9000;   // 16 + 40 x 215, rounded up

    wire        dri_clk;
    wire        rst_n;
    wire        scl;
    wire        sda_out;
    wire        sda_oe;
    wire        sda_line;
    wire        i2c_done;
    wire        bus_err;
    wire [7:0]  i2c_data_r;
    logic       i2c_exec;
    logic       bit_ctrl;
    logic       i2c_rh_wl;
    logic [15:0] i2c_addr;
    logic [7:0] i2c_data_w;
    logic       slave_wide;
    logic       txn_open;                   // a request is in flight
    int         cyc = 0;
    logic [31:0] rng;
    logic [7:0] ref_mem [logic [15:0]];

    tb_clk_gen #(.period_ns(100), .reset_cycles(16)) i_clk_gen (
        .dri_clk (dri_clk),
        .rst_n   (rst_n)
    );

    i2c_master i_i2c_master (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .i2c_exec   (i2c_exec),
        .bit_ctrl   (bit_ctrl),
        .i2c_rh_wl  (i2c_rh_wl),
        .i2c_addr   (i2c_addr),
        .i2c_data_w (i2c_data_w),
        .sda_in     (sda_line),
        .i2c_data_r (i2c_data_r),
        .i2c_done   (i2c_done),
        .scl        (scl),
        .sda_out    (sda_out),
        .sda_oe     (sda_oe)
    );

    i2c_slave_model i_slave (
        .dri_clk  (dri_clk),
        .rst_n    (rst_n),
        .scl      (scl),
        .sda_out  (sda_out),
        .sda_oe   (sda_oe),
        .wide     (slave_wide),
        .sda_line (sda_line),
        .bus_err  (bus_err)
    );

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] fill_byte(input logic [15:0] a);
        return a[15:8] ^ a[7:0] ^ 8'h5a;    // untouched slave memory
    endfunction

    // ----------------------------------------------------------------------
    // bus checks that run all the time
    // ----------------------------------------------------------------------
    a_done_expected: assert property (@(posedge dri_clk) disable iff (!rst_n)
        i2c_done |-> txn_open)
        else fail_now("i2c_done pulsed with no transaction running");

    a_idle_bus: assert property (@(posedge dri_clk) disable iff (!rst_n)
        !txn_open |-> (scl && sda_line))
        else fail_now("bus not idle between transactions");

    a_slave_ok: assert property (@(posedge dri_clk) disable iff (!rst_n)
        !bus_err)
        else fail_now("slave model saw a protocol error");

    always @(posedge dri_clk) begin
        cyc <= cyc + 1;
        if (cyc >= timeout_cycles) fail_now("timeout, the test did not finish in time");
    end

    // ----------------------------------------------------------------------
    // one random transaction
    // ----------------------------------------------------------------------
    task automatic run_txn;
        logic       rd;
        logic       wide;
        logic       stray;
        logic [15:0] addr;
        logic [15:0] ea;
        logic [7:0] data;
        logic [7:0] exp_rd;
        word_addr_u wa;
        logic [7:0] exp_q [$];
        logic [7:0] base;
        int         len;
        int         n;
        int         s_start;
        int         s_restart;
        int         s_stop;
        int         s_nack;
        rng   = next_rand(rng);
        rd    = rng[0];
        wide  = rng[1];
        stray = rng[4];
        addr  = {6'd0, rng[17:16], 5'd0, rng[20:18]};   // small pool, reads hit writes
        data  = rng[31:24];
        ea    = wide ? addr : {8'h00, addr[7:0]};
        wa.word = addr;
        // sladdr, addr_hi, addr_lo, then data_wr or addr_rd
        exp_q.push_back({`I2C_SLAVE_ADDR, 1'b0});
        if (wide) exp_q.push_back(wa.bytes.hi);
        exp_q.push_back(wa.bytes.lo);
        exp_q.push_back(rd ? {`I2C_SLAVE_ADDR, 1'b1} : data);
        len = 40 + (wide ? 36 : 0) + 36 + (rd ? 76 : 36) + 17;
        base      = i_slave.rx_cnt;
        s_start   = i_slave.n_start;
        s_restart = i_slave.n_restart;
        s_stop    = i_slave.n_stop;
        s_nack    = i_slave.n_nack;

        bit_ctrl   = wide;
        i2c_rh_wl  = rd;
        i2c_addr   = addr;
        i2c_data_w = data;
        slave_wide = wide;
        txn_open   = 1'b1;
        i2c_exec   = 1'b1;
        @(negedge dri_clk);
        i2c_exec   = 1'b0;
        bit_ctrl   = !wide;                 // request must be latched
        i2c_rh_wl  = !rd;
        i2c_addr   = ~addr;
        i2c_data_w = ~data;
        n = 1;
        while (!i2c_done) begin
            i2c_exec = stray && n == 60;    // ignored while busy
            @(negedge dri_clk);
            n++;
        end
        assert (n - 1 == len)
            else fail_now($sformatf("Fail i2c_done latency got %h expected %h", n - 1, len));
        if (rd) begin
            exp_rd = ref_mem.exists(ea) ? ref_mem[ea] : fill_byte(ea);
            assert (i2c_data_r === exp_rd)
                else fail_now($sformatf("Fail i2c_data_r got %h expected %h",
                                        i2c_data_r, exp_rd));
        end else begin
            ref_mem[ea] = data;
        end
        @(negedge dri_clk);
        txn_open = 1'b0;
        assert (!i2c_done) else fail_now("i2c_done held for more than one cycle");
        assert (i_slave.n_start == s_start + 1 && i_slave.n_stop == s_stop + 1)
            else fail_now("wrong number of start or stop conditions");
        assert (i_slave.n_restart == s_restart + int'(rd) && i_slave.n_nack == s_nack + int'(rd))
            else fail_now("wrong repeated start or nack count");
        assert (i_slave.rx_cnt - base == 8'(exp_q.size()))
            else fail_now($sformatf("Fail rx_cnt got %h expected %h",
                                    i_slave.rx_cnt - base, exp_q.size()));
        for (int j = 0; j < exp_q.size(); j++) begin
            assert (i_slave.rx_log[base + 8'(j)] === exp_q[j])
                else fail_now($sformatf("Fail rx_log byte %0d got %h expected %h",
                                        j, i_slave.rx_log[base + 8'(j)], exp_q[j]));
        end
        repeat (3) @(negedge dri_clk);
    endtask

    initial begin
        i2c_exec   = 1'b0;
        bit_ctrl   = 1'b0;
        i2c_rh_wl  = 1'b0;
        i2c_addr   = '0;
        i2c_data_w = '0;
        slave_wide = 1'b0;
        txn_open   = 1'b0;
        rng        = 32'd67;
        @(posedge rst_n);
        @(negedge dri_clk);
        assert (scl && sda_line && !i2c_done) else fail_now("bus not idle after reset");
        for (int t = 0; t < num_txn; t++) begin
            run_txn();
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
src/i2c_pkg.sv
src/i2c_txn_ctrl.sv
src/i2c_phase_gen.sv
src/i2c_master.sv
tb/tb_clk_gen.sv
tb/i2c_slave_model.sv
tb/tb_i2c_master.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_i2c_master
FILELIST  := sources.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
